//--- nocArbiter.f
+incdir+.
routerArbPkg.sv
lengthRegister.sv
holdCounter.sv
grantFsm.sv
nocArbiter.sv
nocArbiterTb.sv

//--- nocArbiterModel.svh
`ifndef NOC_ARBITER_MODEL_SVH
`define NOC_ARBITER_MODEL_SVH

// cycle model of the allocator.
// the including module imports routerArbPkg.
lengthT   mdlStored [portCount];
lengthT   mdlCount;
lengthT   mdlLimit;
arbStateT mdlState;

function automatic arbStateT firstRequester(input logic [portCount-1:0] reqs, input int first);
  arbStateT pick;
  int       idx;
  pick = arbIdle;
  for (int k = 0; k < portCount; k++)
  begin
    idx = (first + k) % portCount;
    if (reqs[idx] && pick == arbIdle)
    begin
      pick = arbStateT'(idx + 1);
    end
  end
  return pick;
endfunction

function automatic grantT expectedGrant();
  grantT g;
  g = '0;
  if (mdlState != arbIdle)
  begin
    g[int'(mdlState) - 1] = 1'b1;
  end
  return g;
endfunction

task automatic clearModel();
  for (int k = 0; k < portCount; k++)
  begin
    mdlStored[k] = '0;
  end
  mdlCount = '0;
  mdlLimit = '0;
  mdlState = arbIdle;
endtask

// advances one rising edge using the inputs sampled at that edge.
task automatic advanceModel(input flitIdT ids [portCount], input lengthT lens [portCount],
                            input logic [portCount-1:0] reqs);
  arbStateT next;
  logic     hold;
  int       served;
  hold = 1'b0;
  next = mdlState;
  served = int'(mdlState) - 1;
  if (mdlState == arbIdle)
  begin
    next = firstRequester(reqs, 0);
  end
  else
  begin
    hold = reqs[served] && (mdlCount != mdlLimit);
    if (!hold)
    begin
      next = firstRequester(reqs & ~(grantT'(1) << served), served + 1);
    end
  end
  mdlCount = hold ? mdlCount + 1'b1 : '0;
  if (next != mdlState && next != arbIdle)
  begin
    mdlLimit = mdlStored[int'(next) - 1];
  end
  for (int k = 0; k < portCount; k++)
  begin
    if (ids[k] == headFlitId)
    begin
      mdlStored[k] = lens[k];
    end
  end
  mdlState = next;
endtask

`endif

//--- nocArbiterTb.sv
`timescale 1ns/10ps

module nocArbiterTb;
  import routerArbPkg::*;

  `include "nocArbiterModel.svh"

  localparam int resetCycles = 8;
  localparam int randomCycles = 3000;
  localparam int timeoutCycles = resetCycles + randomCycles + 100;
  localparam time halfPeriod = 20ns;
  localparam time driveDelay = 2ns;

  logic                 clk;
  logic                 rst;
  flitIdT               flitIds [portCount];
  lengthT               lengths [portCount];
  logic [portCount-1:0] reqVec;
  grantT                grant;

  integer seed;
  int     cycleCount;
  int     errorCount;

  nocArbiter u_dut (
    .clk     (clk),
    .rst     (rst),
    .lFlitId (flitIds[0]),
    .nFlitId (flitIds[1]),
    .eFlitId (flitIds[2]),
    .wFlitId (flitIds[3]),
    .sFlitId (flitIds[4]),
    .lLength (lengths[0]),
    .nLength (lengths[1]),
    .eLength (lengths[2]),
    .wLength (lengths[3]),
    .sLength (lengths[4]),
    .lReq    (reqVec[0]),
    .nReq    (reqVec[1]),
    .eReq    (reqVec[2]),
    .wReq    (reqVec[3]),
    .sReq    (reqVec[4]),
    .grant   (grant)
  );

  always #(halfPeriod) clk = ~clk;

  // hard stop in case a wait never ends.
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("timeout: the run did not finish within %0d clock cycles", timeoutCycles);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      errorCount++;
      $display("mismatch %s expected %0h actual %0h", testName, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "first error, run stopped");
    end
  endtask

  // waits one edge, steps the model with the inputs seen at that edge and compares.
  task automatic stepCycle(input string testName);
    flitIdT               idsAtEdge [portCount];
    lengthT               lensAtEdge [portCount];
    logic [portCount-1:0] reqsAtEdge;
    logic                 rstAtEdge;
    @(posedge clk);
    idsAtEdge = flitIds;
    lensAtEdge = lengths;
    reqsAtEdge = reqVec;
    rstAtEdge = rst;
    #(driveDelay);
    if (rstAtEdge)
    begin
      clearModel();
    end
    else
    begin
      advanceModel(idsAtEdge, lensAtEdge, reqsAtEdge);
    end
    checkValue({testName, " one-hot"}, 32'd1, $onehot0(grant));
    checkValue(testName, expectedGrant(), grant);
  endtask

  // presents one flit id and length on a port for a single cycle.
  task automatic loadLength(input string testName, input int port, input flitIdT id,
                            input lengthT len);
    flitIds[port] = id;
    lengths[port] = len;
    stepCycle(testName);
    flitIds[port] = 3'd0;
    lengths[port] = '0;
  endtask

  // counts how long a lone requester keeps the grant it gets from idle.
  task automatic measureHold(input string testName, input int port, input int expected);
    int held;
    held = 0;
    checkValue({testName, " starts idle"}, 32'd0, grant);
    reqVec = grantT'(1 << port);
    stepCycle(testName);
    checkValue({testName, " grant latency"}, grantT'(1 << port), grant);
    while (grant == grantT'(1 << port) && held < 64)
    begin
      held++;
      stepCycle(testName);
    end
    checkValue({testName, " cycles held"}, expected, held);
  endtask

  task automatic dropRequests(input string testName);
    reqVec = '0;
    stepCycle(testName);
    stepCycle(testName);
  endtask

  task automatic driveRandom();
    for (int k = 0; k < portCount; k++)
    begin
      // requests flip rarely so they stay up long enough to time out.
      if ($unsigned($random(seed)) % 8 == 0)
      begin
        reqVec[k] = ~reqVec[k];
      end
      if ($unsigned($random(seed)) % 6 == 0)
      begin
        flitIds[k] = headFlitId;
      end
      else
      begin
        flitIds[k] = flitIdT'(($unsigned($random(seed)) % 7) + 2);
      end
      if ($unsigned($random(seed)) % 16 == 0)
      begin
        lengths[k] = lengthT'($unsigned($random(seed)) % 64);
      end
      else
      begin
        lengths[k] = lengthT'($unsigned($random(seed)) % 16);
      end
    end
  endtask

  initial
  begin
    grantT prevGrant;
    int    waitCycles;
    clk = 1'b0;
    rst = 1'b1;
    reqVec = '0;
    for (int k = 0; k < portCount; k++)
    begin
      flitIds[k] = 3'd0;
      lengths[k] = '0;
    end
    seed = 2201;
    cycleCount = 0;
    errorCount = 0;
    clearModel();

    repeat (resetCycles)
    begin
      stepCycle("reset");
    end
    rst = 1'b0;

    repeat (3)
    begin
      stepCycle("idle after reset");
    end
    checkValue("idle after reset", 32'd0, grant);

    // a non-head flit must leave the stored length at zero.
    loadLength("non-head length", 3, 3'd2, 12'd9);
    measureHold("non-head length", 3, 1);
    dropRequests("non-head length");

    loadLength("head length", 3, headFlitId, 12'd2);
    measureHold("head length", 3, 3);
    dropRequests("head length");

    loadLength("east length", 2, headFlitId, 12'd3);
    measureHold("east hold", 2, 4);
    checkValue("east idle gap", 32'd0, grant);
    stepCycle("east regrant");
    checkValue("east regrant", 5'b00100, grant);
    dropRequests("east release");

    reqVec = 5'b01010;
    stepCycle("fixed priority");
    checkValue("fixed priority", 5'b00010, grant);
    dropRequests("fixed priority");

    // with all ports requesting every grant moves on to the next port.
    reqVec = '1;
    stepCycle("rotation");
    checkValue("rotation start", 5'b00001, grant);
    for (int n = 0; n < 10; n++)
    begin
      prevGrant = grant;
      waitCycles = 0;
      while (grant == prevGrant && waitCycles < 20)
      begin
        waitCycles++;
        stepCycle("rotation");
      end
      checkValue("rotation order", {prevGrant[3:0], prevGrant[4]}, grant);
    end
    dropRequests("rotation");

    for (int c = 0; c < randomCycles; c++)
    begin
      driveRandom();
      stepCycle("random");
    end

    if (errorCount == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- nocArbiter.sv
`timescale 1ns/10ps

module nocArbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  routerArbPkg::flitIdT lFlitId,
  input  routerArbPkg::flitIdT nFlitId,
  input  routerArbPkg::flitIdT eFlitId,
  input  routerArbPkg::flitIdT wFlitId,
  input  routerArbPkg::flitIdT sFlitId,
  input  routerArbPkg::lengthT lLength,
  input  routerArbPkg::lengthT nLength,
  input  routerArbPkg::lengthT eLength,
  input  routerArbPkg::lengthT wLength,
  input  routerArbPkg::lengthT sLength,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  output routerArbPkg::grantT  grant
);
  import routerArbPkg::*;

  lengthT lStored;
  lengthT nStored;
  lengthT eStored;
  lengthT wStored;
  lengthT sStored;
  lengthT limit;
  logic   hold;
  logic   timesUp;

  lengthRegister u_lengthRegister (
    .clk     (clk),
    .rst     (rst),
    .lFlitId (lFlitId),
    .nFlitId (nFlitId),
    .eFlitId (eFlitId),
    .wFlitId (wFlitId),
    .sFlitId (sFlitId),
    .lLength (lLength),
    .nLength (nLength),
    .eLength (eLength),
    .wLength (wLength),
    .sLength (sLength),
    .lStored (lStored),
    .nStored (nStored),
    .eStored (eStored),
    .wStored (wStored),
    .sStored (sStored)
  );

  holdCounter u_holdCounter (
    .clk     (clk),
    .rst     (rst),
    .hold    (hold),
    .limit   (limit),
    .timesUp (timesUp)
  );

  grantFsm u_grantFsm (
    .clk     (clk),
    .rst     (rst),
    .lReq    (lReq),
    .nReq    (nReq),
    .eReq    (eReq),
    .wReq    (wReq),
    .sReq    (sReq),
    .lStored (lStored),
    .nStored (nStored),
    .eStored (eStored),
    .wStored (wStored),
    .sStored (sStored),
    .timesUp (timesUp),
    .hold    (hold),
    .limit   (limit),
    .grant   (grant)
  );

endmodule

//--- grantFsm.sv
`timescale 1ns/10ps

module grantFsm (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  input  routerArbPkg::lengthT lStored,
  input  routerArbPkg::lengthT nStored,
  input  routerArbPkg::lengthT eStored,
  input  routerArbPkg::lengthT wStored,
  input  routerArbPkg::lengthT sStored,
  input  logic                 timesUp,
  output logic                 hold,
  output routerArbPkg::lengthT limit,
  output routerArbPkg::grantT  grant
);
  import routerArbPkg::*;

  arbStateT             state;
  arbStateT             nextState;
  logic [portCount-1:0] req;
  lengthT               stored [portCount];
  logic [2:0]           servedIdx;
  logic [2:0]           nextIdx;

  // first requester found when scanning from port first, wrapping around.
  function automatic arbStateT pickNext(input logic [portCount-1:0] reqs, input int first);
    arbStateT pick;
    int       idx;
    pick = arbIdle;
    // scan backwards so the nearest requester is the last one written.
    for (int k = portCount - 1; k >= 0; k--)
    begin
      idx = (first + k) % portCount;
      if (reqs[idx])
      begin
        pick = arbStateT'(idx + 1);
      end
    end
    return pick;
  endfunction

  assign req = {sReq, wReq, eReq, nReq, lReq};

  assign stored[0] = lStored;
  assign stored[1] = nStored;
  assign stored[2] = eStored;
  assign stored[3] = wStored;
  assign stored[4] = sStored;

  assign servedIdx = state - 3'd1;
  assign nextIdx = nextState - 3'd1;

  always_comb
  begin
    grant = '0;
    if (state != arbIdle)
    begin
      grant[servedIdx] = 1'b1;
    end
  end

  always_comb
  begin
    hold = 1'b0;
    nextState = state;
    if (state == arbIdle)
    begin
      // fixed priority from idle, local first.
      nextState = pickNext(req, 0);
    end
    else
    begin
      hold = req[servedIdx] && !timesUp;
      if (!hold)
      begin
        // rotate past the served port and leave it out of the search.
        nextState = pickNext(req & ~grant, int'(servedIdx) + 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
      limit <= '0;
    end
    else
    begin
      state <= nextState;
      // length is captured at grant entry; later loads apply to the next grant.
      if (nextState != state && nextState != arbIdle)
      begin
        limit <= stored[nextIdx];
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is not one-hot");

  assert property (@(posedge clk) disable iff (rst) (state == arbIdle) |-> !hold)
    else $error("hold raised while idle");

endmodule

//--- holdCounter.sv
`timescale 1ns/10ps

module holdCounter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hold,
  input  routerArbPkg::lengthT limit,
  output logic                 timesUp
);
  import routerArbPkg::*;

  lengthT count;

  // count restarts from zero whenever the grant is not being held.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (hold)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == limit);

  // the limit is latched by the grant FSM for the whole grant, so a held
  // count must stop at it.
  assert property (@(posedge clk) disable iff (rst) hold |-> count <= limit)
    else $error("hold count passed its limit");

endmodule

//--- lengthRegister.sv
`timescale 1ns/10ps

module lengthRegister (
  input  logic                   clk,
  input  logic                   rst,
  input  routerArbPkg::flitIdT   lFlitId,
  input  routerArbPkg::flitIdT   nFlitId,
  input  routerArbPkg::flitIdT   eFlitId,
  input  routerArbPkg::flitIdT   wFlitId,
  input  routerArbPkg::flitIdT   sFlitId,
  input  routerArbPkg::lengthT   lLength,
  input  routerArbPkg::lengthT   nLength,
  input  routerArbPkg::lengthT   eLength,
  input  routerArbPkg::lengthT   wLength,
  input  routerArbPkg::lengthT   sLength,
  output routerArbPkg::lengthT   lStored,
  output routerArbPkg::lengthT   nStored,
  output routerArbPkg::lengthT   eStored,
  output routerArbPkg::lengthT   wStored,
  output routerArbPkg::lengthT   sStored
);
  import routerArbPkg::*;

  // each port keeps the packet length of its most recent head flit.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lStored <= '0;
      nStored <= '0;
      eStored <= '0;
      wStored <= '0;
      sStored <= '0;
    end
    else
    begin
      if (lFlitId == headFlitId)
      begin
        lStored <= lLength;
      end
      if (nFlitId == headFlitId)
      begin
        nStored <= nLength;
      end
      if (eFlitId == headFlitId)
      begin
        eStored <= eLength;
      end
      if (wFlitId == headFlitId)
      begin
        wStored <= wLength;
      end
      if (sFlitId == headFlitId)
      begin
        sStored <= sLength;
      end
    end
  end

endmodule

//--- routerArbPkg.sv
package routerArbPkg;

  localparam int portCount = 5;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;

  // flit type code carried alongside each flit.
  typedef logic [flitIdWidth-1:0] flitIdT;

  // timeout length in clock cycles.
  typedef logic [lengthWidth-1:0] lengthT;

  // one-hot grant, bit 0 is local, then north, east, west, south.
  typedef logic [portCount-1:0] grantT;

  localparam flitIdT headFlitId = 3'd1;

  // grant states follow the port order, so state minus one is the port index.
  typedef enum logic [2:0] {
    arbIdle    = 3'd0,
    grantLocal = 3'd1,
    grantNorth = 3'd2,
    grantEast  = 3'd3,
    grantWest  = 3'd4,
    grantSouth = 3'd5
  } arbStateT;

endpackage
